// ==== exec_pkg.sv ====
package exec_pkg;

	// Instruction format fields
	typedef logic [31:0] word_t;
	typedef logic [5:0]  inst_num_t;
	typedef logic [15:0] imm16_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [25:0] jaddr_t;

	// Add/subtract
	localparam inst_num_t OP_ADD  = 6'd8;
	localparam inst_num_t OP_ADDI = 6'd9;
	localparam inst_num_t OP_SUB  = 6'd10;
	localparam inst_num_t OP_SUBI = 6'd11;

	// Multiply/divide
	localparam inst_num_t OP_MUL  = 6'd12;
	localparam inst_num_t OP_DIVU = 6'd13;

	// Bit and shift
	localparam inst_num_t OP_AND  = 6'd16;
	localparam inst_num_t OP_ANDI = 6'd17;
	localparam inst_num_t OP_OR   = 6'd18;
	localparam inst_num_t OP_ORI  = 6'd19;
	localparam inst_num_t OP_XOR  = 6'd20;
	localparam inst_num_t OP_XORI = 6'd21;
	localparam inst_num_t OP_NOR  = 6'd22;
	localparam inst_num_t OP_SLL  = 6'd23;
	localparam inst_num_t OP_SRL  = 6'd24;
	localparam inst_num_t OP_SRA  = 6'd25;
	localparam inst_num_t OP_SLT  = 6'd26;
	localparam inst_num_t OP_LUI  = 6'd27;

	// Word memory access
	localparam inst_num_t OP_LW   = 6'd28;
	localparam inst_num_t OP_SW   = 6'd29;

	// Branch and jump
	localparam inst_num_t OP_BEQ  = 6'd32;
	localparam inst_num_t OP_BNE  = 6'd33;
	localparam inst_num_t OP_BLT  = 6'd34;
	localparam inst_num_t OP_BGE  = 6'd35;
	localparam inst_num_t OP_J    = 6'd36;
	localparam inst_num_t OP_JAL  = 6'd37;
	localparam inst_num_t OP_JR   = 6'd38;

	localparam int MULDIV_STEPS = 32; // One quotient or partial product bit per step

	typedef enum logic [2:0] {
		CAT_ALU,
		CAT_MULDIV,
		CAT_MEM,
		CAT_BRANCH,
		CAT_NONE
	} exec_cat_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ALU,    // Single cycle completion, also branches and unknown numbers
		ST_MULDIV,
		ST_MEM,
		ST_DONE    // completed is high here
	} ctrl_state_t;

endpackage

// ==== exec_op_if.sv ====
interface exec_op_if
	import exec_pkg::*;
();

	inst_num_t inst_num;
	imm16_t    const16;
	shamt_t    shift5;
	jaddr_t    addr26;
	word_t     pc;
	word_t     rs;
	word_t     rt;

	// Operation as latched by the controller at start
	modport ctrl (
		output inst_num, const16, shift5, addr26, pc, rs, rt
	);

	modport elem (
		input inst_num, const16, shift5, addr26, pc, rs, rt
	);

endinterface

// ==== exec_ctrl.sv ====
module exec_ctrl
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      start,
	input  inst_num_t inst_num,
	input  imm16_t    const16,
	input  shamt_t    shift5,
	input  jaddr_t    addr26,
	input  word_t     pc,
	input  word_t     rs,
	input  word_t     rt,
	exec_op_if.ctrl   op,
	output logic      alu_go,
	output logic      timer_load,
	input  logic      timer_last,
	input  word_t     alu_result,
	output logic      mem_go,
	input  logic      mem_done,
	input  word_t     mem_result,
	input  word_t     next_pc,
	input  word_t     link,
	output logic      completed,
	output word_t     exec_reg_out,
	output word_t     exec_pc_out
);

	ctrl_state_t state;
	exec_cat_t   cat;
	inst_num_t   cur_num;
	word_t       sel_result;

	// In idle the incoming number is classified, afterwards the latched one
	assign cur_num = (state == ST_IDLE) ? inst_num : op.inst_num;

	always_comb begin
		if (cur_num inside {[OP_ADD:OP_SUBI], [OP_AND:OP_LUI]})
			cat = CAT_ALU;
		else if (cur_num inside {[OP_MUL:OP_DIVU]})
			cat = CAT_MULDIV;
		else if (cur_num inside {[OP_LW:OP_SW]})
			cat = CAT_MEM;
		else if (cur_num inside {[OP_BEQ:OP_JR]})
			cat = CAT_BRANCH;
		else
			cat = CAT_NONE;
	end

	always_comb begin
		case (cat)
			CAT_ALU, CAT_MULDIV: sel_result = alu_result;
			CAT_MEM:             sel_result = mem_result;
			CAT_BRANCH:          sel_result = link;
			default:             sel_result = '0;
		endcase
	end

	// Memory request goes out in the start cycle to save a cycle
	assign mem_go = (state == ST_IDLE) && start && (cat == CAT_MEM);
	assign completed = (state == ST_DONE);

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			op.inst_num <= inst_num;
			op.const16  <= const16;
			op.shift5   <= shift5;
			op.addr26   <= addr26;
			op.pc       <= pc;
			op.rs       <= rs;
			op.rt       <= rt;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= ST_IDLE;
			alu_go       <= 1'b0;
			timer_load   <= 1'b0;
			exec_reg_out <= '0;
			exec_pc_out  <= '0;
		end else begin
			alu_go     <= 1'b0;
			timer_load <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						alu_go     <= (cat == CAT_ALU) || (cat == CAT_MULDIV);
						timer_load <= (cat == CAT_MULDIV);
						if (cat == CAT_MULDIV)
							state <= ST_MULDIV;
						else if (cat == CAT_MEM)
							state <= ST_MEM;
						else
							state <= ST_ALU;
					end
				end
				ST_ALU: begin
					state        <= ST_DONE;
					exec_reg_out <= sel_result;
					exec_pc_out  <= next_pc;
				end
				ST_MULDIV: begin
					if (timer_last) begin // ALU shows the final step's value
						state        <= ST_DONE;
						exec_reg_out <= sel_result;
						exec_pc_out  <= next_pc;
					end
				end
				ST_MEM: begin
					if (mem_done) begin
						state        <= ST_DONE;
						exec_reg_out <= sel_result;
						exec_pc_out  <= next_pc;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== exec_step_timer.sv ====
module exec_step_timer
	import exec_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic load,
	output logic step,
	output logic last
);

	logic [5:0] count; // Steps still to go

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			count <= '0;
		else if (load)
			count <= 6'(MULDIV_STEPS);
		else if (step)
			count <= count - 6'd1;
	end

	assign step = (count != '0);
	assign last = (count == 6'd1);

endmodule

// ==== exec_alu.sv ====
module exec_alu
	import exec_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	exec_op_if.elem op,
	input  logic    go,
	input  logic    step,
	output word_t   result
);

	word_t simm;
	word_t zimm;

	// Shift-add multiply
	word_t mcand;
	word_t mplier;
	word_t acc;
	word_t acc_next;

	// Restoring divide, quo starts as the dividend and fills with quotient bits
	word_t        rem;
	word_t        quo;
	word_t        rem_next;
	word_t        quo_next;
	logic  [32:0] rem_wide;
	logic  [32:0] diff;

	assign simm = {{16{op.const16[15]}}, op.const16};
	assign zimm = {16'b0, op.const16};

	assign acc_next = acc + (mplier[0] ? mcand : '0);

	always_comb begin
		rem_wide = {rem, quo[31]};
		diff     = rem_wide - {1'b0, op.rt};
		if (!diff[32]) begin // No borrow, divisor fits
			rem_next = diff[31:0];
			quo_next = {quo[30:0], 1'b1};
		end else begin
			rem_next = rem_wide[31:0];
			quo_next = {quo[30:0], 1'b0};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mcand  <= '0;
			mplier <= '0;
			acc    <= '0;
			rem    <= '0;
			quo    <= '0;
		end else if (go) begin
			mcand  <= op.rs;
			mplier <= op.rt;
			acc    <= '0;
			rem    <= '0;
			quo    <= op.rs;
		end else if (step) begin
			mcand  <= {mcand[30:0], 1'b0};
			mplier <= {1'b0, mplier[31:1]};
			acc    <= acc_next;
			rem    <= rem_next;
			quo    <= quo_next;
		end
	end

	// Shift operand is rs
	always_comb begin
		case (op.inst_num)
			OP_ADD:  result = op.rs + op.rt;
			OP_ADDI: result = op.rs + simm;
			OP_SUB:  result = op.rs - op.rt;
			OP_SUBI: result = op.rs - simm;
			OP_MUL:  result = acc_next;  // Final on the last step
			OP_DIVU: result = quo_next;
			OP_AND:  result = op.rs & op.rt;
			OP_ANDI: result = op.rs & zimm;
			OP_OR:   result = op.rs | op.rt;
			OP_ORI:  result = op.rs | zimm;
			OP_XOR:  result = op.rs ^ op.rt;
			OP_XORI: result = op.rs ^ zimm;
			OP_NOR:  result = ~(op.rs | op.rt);
			OP_SLL:  result = op.rs << op.shift5;
			OP_SRL:  result = op.rs >> op.shift5;
			OP_SRA:  result = $signed(op.rs) >>> op.shift5;
			OP_SLT:  result = {31'b0, $signed(op.rs) < $signed(op.rt)};
			OP_LUI:  result = {op.const16, 16'b0};
			default: result = '0;
		endcase
	end

endmodule

// ==== exec_branch.sv ====
module exec_branch
	import exec_pkg::*;
(
	exec_op_if.elem op,
	output word_t   next_pc,
	output word_t   link
);

	word_t pc4;
	word_t br_target;
	word_t j_target;
	logic  taken;

	assign pc4       = op.pc + 32'd4;
	assign br_target = pc4 + {{14{op.const16[15]}}, op.const16, 2'b00};
	assign j_target  = {pc4[31:28], op.addr26, 2'b00};

	always_comb begin
		case (op.inst_num)
			OP_BEQ:  taken = (op.rs == op.rt);
			OP_BNE:  taken = (op.rs != op.rt);
			OP_BLT:  taken = ($signed(op.rs) < $signed(op.rt));
			OP_BGE:  taken = ($signed(op.rs) >= $signed(op.rt));
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		next_pc = pc4; // Fall-through for every other instruction
		link    = '0;
		case (op.inst_num)
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE: begin
				if (taken)
					next_pc = br_target;
			end
			OP_J:  next_pc = j_target;
			OP_JAL: begin
				next_pc = j_target;
				link    = pc4;
			end
			OP_JR: next_pc = op.rs;
			default: ;
		endcase
	end

endmodule

// ==== exec_mem.sv ====
module exec_mem
	import exec_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	exec_op_if.elem op,
	input  logic    go,
	output logic    done,
	output word_t   load_data,
	output word_t   main_mem_in_addr,
	output word_t   main_mem_in_data,
	output logic    main_mem_in_valid,
	input  logic    main_mem_in_ready,
	output word_t   main_mem_out_addr,
	output logic    main_mem_out_valid,
	input  word_t   main_mem_out_data,
	input  logic    main_mem_out_ready
);

	logic  req;      // Request outstanding
	logic  is_store;
	logic  accepted;
	word_t addr;

	// go arrives before the operation is latched, direction follows from op
	assign is_store = (op.inst_num == OP_SW);
	assign addr     = op.rs + {{16{op.const16[15]}}, op.const16};

	assign main_mem_in_addr   = addr;
	assign main_mem_in_data   = op.rt;
	assign main_mem_in_valid  = req && is_store;
	assign main_mem_out_addr  = addr;
	assign main_mem_out_valid = req && !is_store;

	assign accepted = is_store ? main_mem_in_ready : main_mem_out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req  <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= req && accepted;
			if (go)
				req <= 1'b1;
			else if (accepted)
				req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (go)
			load_data <= '0; // Stores return zero
		else if (main_mem_out_valid && main_mem_out_ready)
			load_data <= main_mem_out_data;
	end

endmodule

// ==== exec_unit.sv ====
module exec_unit
	import exec_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      start,
	input  inst_num_t inst_num,
	input  imm16_t    const16,
	input  shamt_t    shift5,
	input  jaddr_t    addr26,
	input  word_t     pc,
	input  word_t     rs,
	input  word_t     rt,
	output logic      completed,
	output word_t     exec_reg_out,
	output word_t     exec_pc_out,

	output word_t     main_mem_in_addr,
	output word_t     main_mem_in_data,
	output logic      main_mem_in_valid,
	input  logic      main_mem_in_ready,
	output word_t     main_mem_out_addr,
	output logic      main_mem_out_valid,
	input  word_t     main_mem_out_data,
	input  logic      main_mem_out_ready
);

	logic  alu_go;
	logic  timer_load;
	logic  timer_step;
	logic  timer_last;
	logic  mem_go;
	logic  mem_done;
	word_t alu_result;
	word_t mem_result;
	word_t next_pc;
	word_t link;

	exec_op_if op_bus();

	exec_ctrl ctrl (
		.op(op_bus.ctrl), .*);

	exec_step_timer step_timer (
		.clk, .arst_n, .load(timer_load), .step(timer_step), .last(timer_last));

	exec_alu alu (
		.clk, .arst_n, .op(op_bus.elem), .go(alu_go), .step(timer_step),
		.result(alu_result));

	exec_branch branch (
		.op(op_bus.elem), .next_pc, .link);

	exec_mem mem (
		.op(op_bus.elem), .go(mem_go), .done(mem_done), .load_data(mem_result), .*);

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model
	import exec_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  word_t in_addr,
	input  word_t in_data,
	input  logic  in_valid,
	output logic  in_ready,
	input  word_t out_addr,
	input  logic  out_valid,
	output word_t out_data,
	output logic  out_ready,
	output word_t seen_addr, // Address of the last accepted request
	output word_t seen_data  // Data of the last accepted write
);
	timeunit 1ns;
	timeprecision 1ps;

	word_t words [64];
	word_t rng;
	int    delay; // Cycles left before ready, -1 when nothing is pending

	function automatic word_t xorshift(word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	initial begin
		in_ready  = 1'b0;
		out_ready = 1'b0;
		out_data  = '0;
		seen_addr = '0;
		seen_data = '0;
		for (int i = 0; i < 64; i++)
			words[i] = (32'(i) * 32'h9E3779B9) ^ 32'h00FF00FF;
	end

	// Ready changes on the falling edge and is sampled by the DUT on the rising one
	always @(negedge clk or negedge arst_n) begin
		in_ready  = 1'b0;
		out_ready = 1'b0;
		if (!arst_n) begin
			rng   = 32'd54958;
			delay = -1;
		end else if (in_valid || out_valid) begin
			if (delay < 0) begin
				rng   = xorshift(rng);
				delay = int'(rng[1:0]); // 0 to 3 cycles
			end
			if (delay == 0) begin
				seen_addr = in_valid ? in_addr : out_addr;
				if (in_valid) begin
					words[in_addr[7:2]] = in_data;
					seen_data = in_data;
				end else
					out_data = words[out_addr[7:2]];
				in_ready  = in_valid;
				out_ready = out_valid;
			end
			delay--;
		end
	end

endmodule

// ==== tb_exec_unit.sv ====
module tb_exec_unit
	import exec_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD     = 8;
	localparam int CYCLES_PER_ROW = 60;

	typedef struct packed {
		inst_num_t num;
		imm16_t    imm;
		shamt_t    sh;
		jaddr_t    ja;
		word_t     pc;
		word_t     rs;
		word_t     rt;
		word_t     exp_reg;
		word_t     exp_pc;
	} row_t;

	logic      clk;
	logic      arst_n;
	logic      start;
	inst_num_t inst_num;
	imm16_t    const16;
	shamt_t    shift5;
	jaddr_t    addr26;
	word_t     pc;
	word_t     rs;
	word_t     rt;
	logic      completed;
	word_t     exec_reg_out;
	word_t     exec_pc_out;
	word_t     main_mem_in_addr;
	word_t     main_mem_in_data;
	logic      main_mem_in_valid;
	logic      main_mem_in_ready;
	word_t     main_mem_out_addr;
	logic      main_mem_out_valid;
	word_t     main_mem_out_data;
	logic      main_mem_out_ready;
	word_t     seen_addr;
	word_t     seen_data;

	row_t rows[$];
	row_t busy_row;
	int   errors;
	int   rows_run;

	exec_unit DUT (.*);

	tb_mem_model mem_model (
		.clk, .arst_n,
		.in_addr(main_mem_in_addr), .in_data(main_mem_in_data),
		.in_valid(main_mem_in_valid), .in_ready(main_mem_in_ready),
		.out_addr(main_mem_out_addr), .out_valid(main_mem_out_valid),
		.out_data(main_mem_out_data), .out_ready(main_mem_out_ready),
		.seen_addr, .seen_data);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic void add_row(inst_num_t num, imm16_t imm, shamt_t sh, jaddr_t ja,
		word_t pc_v, word_t rs_v, word_t rt_v, word_t exp_reg, word_t exp_pc);
		rows.push_back(row_t'{num, imm, sh, ja, pc_v, rs_v, rt_v, exp_reg, exp_pc});
	endfunction

	function automatic void report_mismatch(string name, word_t got, word_t exp, inst_num_t num);
		errors++;
		$display("CHECK FAILED %s: got %h, expected %h (instruction %0d)", name, got, exp, num);
	endfunction

	// Zero means a memory access, which has no fixed length
	function automatic int expected_cycles(inst_num_t num);
		if (num == OP_MUL || num == OP_DIVU)
			return 34;
		if (num == OP_LW || num == OP_SW)
			return 0;
		return 2;
	endfunction

	// Entered on a falling edge with the controller idle
	task automatic run_row(input row_t r, input int busy_at);
		int    cycles;
		int    want;
		word_t exp_addr;
		want     = expected_cycles(r.num);
		exp_addr = r.rs + word_t'(int'(shortint'(r.imm)));
		inst_num = r.num;
		const16  = r.imm;
		shift5   = r.sh;
		addr26   = r.ja;
		pc       = r.pc;
		rs       = r.rs;
		rt       = r.rt;
		start    = 1'b1;
		cycles   = 0;
		do begin
			@(negedge clk);
			cycles++;
			start = (cycles == busy_at); // Extra start while busy
			pc    = ~r.pc;               // Fields are latched at start
			rs    = ~r.rs;
			rt    = ~r.rt;
		end while (!completed);
		rows_run++;
		if ((want != 0) ? (cycles != want) : (cycles < 3)) begin
			errors++;
			$display("Instruction %0d took %0d cycles to complete, outside its timing",
				r.num, cycles);
		end
		if (exec_reg_out !== r.exp_reg)
			report_mismatch("exec_reg_out", exec_reg_out, r.exp_reg, r.num);
		if (exec_pc_out !== r.exp_pc)
			report_mismatch("exec_pc_out", exec_pc_out, r.exp_pc, r.num);
		if ((r.num == OP_LW || r.num == OP_SW) && seen_addr !== exp_addr)
			report_mismatch("main_mem address", seen_addr, exp_addr, r.num);
		if (r.num == OP_SW && seen_data !== r.rt)
			report_mismatch("main_mem_in_data", seen_data, r.rt, r.num);
		@(negedge clk);
		if (completed) begin
			errors++;
			$display("completed stayed high for more than one cycle (instruction %0d)", r.num);
		end
	endtask

	initial begin
		arst_n   = 1'b0;
		start    = 1'b0;
		inst_num = '0;
		const16  = '0;
		shift5   = '0;
		addr26   = '0;
		pc       = '0;
		rs       = '0;
		rt       = '0;
		errors   = 0;
		rows_run = 0;

		// num, const16, shift5, addr26, pc, rs, rt, expected reg, expected pc
		add_row(OP_ADD, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h5, 32'h7, 32'hC, 32'h1004);
		add_row(OP_ADDI, 16'hFFFE, 5'd0, 26'h0, 32'h1000, 32'h100, 32'h0, 32'hFE, 32'h1004);
		add_row(OP_SUB, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h3, 32'h5, 32'hFFFFFFFE, 32'h1004);
		add_row(OP_SUBI, 16'h8000, 5'd0, 26'h0, 32'h1000, 32'h10, 32'h0, 32'h8010, 32'h1004);
		add_row(OP_AND, 16'h0, 5'd0, 26'h0, 32'h1000, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000,
			32'h1004);
		add_row(OP_ANDI, 16'h8001, 5'd0, 26'h0, 32'h1000, 32'hFFFFFFFF, 32'h0, 32'h8001, 32'h1004);
		add_row(OP_OR, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h12340000, 32'h5678, 32'h12345678, 32'h1004);
		add_row(OP_ORI, 16'hABCD, 5'd0, 26'h0, 32'h1000, 32'h12340000, 32'h0, 32'h1234ABCD,
			32'h1004);
		add_row(OP_XOR, 16'h0, 5'd0, 26'h0, 32'h1000, 32'hFFFF0000, 32'h0F0F0F0F, 32'hF0F00F0F,
			32'h1004);
		add_row(OP_XORI, 16'h8000, 5'd0, 26'h0, 32'h1000, 32'hFFFFFFFF, 32'h0, 32'hFFFF7FFF,
			32'h1004);
		add_row(OP_NOR, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h0F0F0000, 32'hFF, 32'hF0F0FF00, 32'h1004);
		add_row(OP_SLL, 16'h0, 5'd4, 26'h0, 32'h1000, 32'h3, 32'h0, 32'h30, 32'h1004);
		add_row(OP_SRL, 16'h0, 5'd31, 26'h0, 32'h1000, 32'h80000000, 32'h0, 32'h1, 32'h1004);
		add_row(OP_SRA, 16'h0, 5'd4, 26'h0, 32'h1000, 32'h80000010, 32'h0, 32'hF8000001, 32'h1004);
		add_row(OP_SLT, 16'h0, 5'd0, 26'h0, 32'h1000, 32'hFFFFFFFF, 32'h1, 32'h1, 32'h1004);
		add_row(OP_SLT, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h1, 32'hFFFFFFFF, 32'h0, 32'h1004);
		add_row(OP_LUI, 16'hBEEF, 5'd0, 26'h0, 32'h1000, 32'h1234, 32'h0, 32'hBEEF0000, 32'h1004);
		add_row(OP_MUL, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h10003, 32'h20005, 32'h000B000F, 32'h1004);
		add_row(OP_MUL, 16'h0, 5'd0, 26'h0, 32'h1000, 32'hFFFFFFFF, 32'h7, 32'hFFFFFFF9, 32'h1004);
		add_row(OP_DIVU, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h64, 32'h7, 32'hE, 32'h1004);
		add_row(OP_DIVU, 16'h0, 5'd0, 26'h0, 32'h1000, 32'hFFFFFFFF, 32'h10, 32'h0FFFFFFF, 32'h1004);
		add_row(OP_DIVU, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h1234, 32'h0, 32'hFFFFFFFF, 32'h1004);
		add_row(OP_SW, 16'hFFF8, 5'd0, 26'h0, 32'h1000, 32'h40, 32'hCAFEF00D, 32'h0, 32'h1004);
		add_row(OP_LW, 16'h0008, 5'd0, 26'h0, 32'h1000, 32'h30, 32'h0, 32'hCAFEF00D, 32'h1004);
		add_row(OP_SW, 16'h0004, 5'd0, 26'h0, 32'h1000, 32'h80, 32'h13579BDF, 32'h0, 32'h1004);
		add_row(OP_LW, 16'hFFF4, 5'd0, 26'h0, 32'h1000, 32'h90, 32'h0, 32'h13579BDF, 32'h1004);
		add_row(OP_BEQ, 16'hFFFC, 5'd0, 26'h0, 32'h2000, 32'h5, 32'h5, 32'h0, 32'h1FF4);
		add_row(OP_BEQ, 16'hFFFC, 5'd0, 26'h0, 32'h2000, 32'h5, 32'h6, 32'h0, 32'h2004);
		add_row(OP_BNE, 16'h0010, 5'd0, 26'h0, 32'h2000, 32'h5, 32'h6, 32'h0, 32'h2044);
		add_row(OP_BNE, 16'h0010, 5'd0, 26'h0, 32'h2000, 32'h5, 32'h5, 32'h0, 32'h2004);
		add_row(OP_BLT, 16'hFFF0, 5'd0, 26'h0, 32'h2000, 32'hFFFFFFFE, 32'h1, 32'h0, 32'h1FC4);
		add_row(OP_BLT, 16'hFFF0, 5'd0, 26'h0, 32'h2000, 32'h1, 32'hFFFFFFFE, 32'h0, 32'h2004);
		add_row(OP_BGE, 16'hFF00, 5'd0, 26'h0, 32'h2000, 32'h3, 32'h3, 32'h0, 32'h1C04);
		add_row(OP_BGE, 16'hFF00, 5'd0, 26'h0, 32'h2000, 32'hFFFFFFFF, 32'h0, 32'h0, 32'h2004);
		add_row(OP_J, 16'h0, 5'd0, 26'h123456, 32'h30000ABC, 32'h0, 32'h0, 32'h0, 32'h3048D158);
		add_row(OP_JAL, 16'h0, 5'd0, 26'h10, 32'h4FFFFFFC, 32'h0, 32'h0, 32'h50000000,
			32'h50000040);
		add_row(OP_JR, 16'h0, 5'd0, 26'h0, 32'h2000, 32'h8000, 32'h0, 32'h0, 32'h8000);
		add_row(6'd5, 16'h0, 5'd0, 26'h0, 32'h100, 32'h55, 32'h0, 32'h0, 32'h104);
		add_row(6'd60, 16'h0, 5'd0, 26'h0, 32'hFFFFFFFC, 32'h0, 32'h0, 32'h0, 32'h0);

		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		if (completed || main_mem_in_valid || main_mem_out_valid) begin
			errors++;
			$display("completed or a memory valid is high after reset");
		end
		if (exec_reg_out !== '0)
			report_mismatch("exec_reg_out", exec_reg_out, '0, 6'd0);
		if (exec_pc_out !== '0)
			report_mismatch("exec_pc_out", exec_pc_out, '0, 6'd0);

		foreach (rows[i])
			run_row(rows[i], 0);

		// A second start during a multiply must change neither result nor timing
		busy_row = '{OP_MUL, 16'h0, 5'd0, 26'h0, 32'h1000, 32'h6, 32'h7, 32'h2A, 32'h1004};
		run_row(busy_row, 5);
		repeat (expected_cycles(OP_MUL) + 2) begin
			@(negedge clk);
			if (completed) begin
				errors++;
				$display("completed raised again after a start given while busy");
			end
		end

		$display("Rows run: %0d, errors: %0d", rows_run, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int limit;
		#1;
		limit = (rows.size() + 3) * CYCLES_PER_ROW * CLK_PERIOD;
		#(limit);
		$display("Timeout: the run did not finish within %0d ns", limit);
		$display("Rows run: %0d, errors: %0d", rows_run, errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== exec_unit.f ====
exec_pkg.sv
exec_op_if.sv
exec_ctrl.sv
exec_step_timer.sv
exec_alu.sv
exec_branch.sv
exec_mem.sv
exec_unit.sv
tb_mem_model.sv
tb_exec_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_exec_unit \
	-f exec_unit.f -o tb_exec_unit
./obj_dir/tb_exec_unit > sim.log
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
